/* bench/tb_encode.svh */
function automatic ctl_pkg::instr_t r_word(
	input logic [5:0] funct,
	input ctl_pkg::reg_addr_t rs, rt, rd,
	input logic [4:0] shamt
);
	return {6'h00, rs, rt, rd, shamt, funct};
endfunction

function automatic ctl_pkg::instr_t i_word(
	input logic [5:0] op,
	input ctl_pkg::reg_addr_t rs, rt,
	input logic [15:0] imm
);
	return {op, rs, rt, imm};
endfunction

// sll and lui keep rs at zero, and jr keeps rt and rd at zero.
function automatic ctl_pkg::instr_t encode(
	input ctl_pkg::kind_t kind,
	input ctl_pkg::reg_addr_t rs, rt, rd
);
	case (kind)
		ctl_pkg::kind_addu: return r_word(6'h21, rs, rt, rd, 5'd0);
		ctl_pkg::kind_subu: return r_word(6'h23, rs, rt, rd, 5'd0);
		ctl_pkg::kind_and: return r_word(6'h24, rs, rt, rd, 5'd0);
		ctl_pkg::kind_or: return r_word(6'h25, rs, rt, rd, 5'd0);
		ctl_pkg::kind_slt: return r_word(6'h2a, rs, rt, rd, 5'd0);
		ctl_pkg::kind_sll: return r_word(6'h00, 5'd0, rt, rd, 5'd3); // never the all-zero word.
		ctl_pkg::kind_ori: return i_word(6'h0d, rs, rt, 16'h00f0);
		ctl_pkg::kind_addiu: return i_word(6'h09, rs, rt, 16'hfff8);
		ctl_pkg::kind_lui: return i_word(6'h0f, 5'd0, rt, 16'h1234);
		ctl_pkg::kind_lw: return i_word(6'h23, rs, rt, 16'h0010);
		ctl_pkg::kind_sw: return i_word(6'h2b, rs, rt, 16'h0010);
		ctl_pkg::kind_beq: return i_word(6'h04, rs, rt, 16'h0004);
		ctl_pkg::kind_bne: return i_word(6'h05, rs, rt, 16'h0004);
		ctl_pkg::kind_j: return {6'h02, 26'h0000100};
		ctl_pkg::kind_jal: return {6'h03, 26'h0000200};
		ctl_pkg::kind_jr: return r_word(6'h08, rs, 5'd0, 5'd0, 5'd0);
		default: return '0;
	endcase
endfunction

function automatic ctl_pkg::stage_info_t make_record(
	input ctl_pkg::kind_t kind,
	input ctl_pkg::dp_class_t dp_class,
	input ctl_pkg::reg_addr_t reg1, reg2, regw
);
	ctl_pkg::stage_info_t r;
	r.kind = kind;
	r.dp_class = dp_class;
	r.reg1 = reg1;
	r.reg2 = reg2;
	r.regw = regw;
	return r;
endfunction

function automatic ctl_pkg::stage_info_t bubble();
	return make_record(ctl_pkg::kind_nop, ctl_pkg::none, 5'd0, 5'd0, 5'd0);
endfunction

// the record that decode should produce for the word from encode.
function automatic ctl_pkg::stage_info_t record_of(
	input ctl_pkg::kind_t kind,
	input ctl_pkg::reg_addr_t rs, rt, rd
);
	case (kind)
		ctl_pkg::kind_addu, ctl_pkg::kind_subu, ctl_pkg::kind_and,
		ctl_pkg::kind_or, ctl_pkg::kind_slt:
			return make_record(kind, ctl_pkg::cal_r, rs, rt, rd);
		ctl_pkg::kind_sll: return make_record(kind, ctl_pkg::cal_r, 5'd0, rt, rd);
		ctl_pkg::kind_ori, ctl_pkg::kind_addiu:
			return make_record(kind, ctl_pkg::cal_i, rs, 5'd0, rt);
		ctl_pkg::kind_lui: return make_record(kind, ctl_pkg::cal_i, 5'd0, 5'd0, rt);
		ctl_pkg::kind_lw: return make_record(kind, ctl_pkg::load, rs, 5'd0, rt);
		ctl_pkg::kind_sw: return make_record(kind, ctl_pkg::store, rs, rt, 5'd0);
		ctl_pkg::kind_beq, ctl_pkg::kind_bne:
			return make_record(kind, ctl_pkg::branch, rs, rt, 5'd0);
		ctl_pkg::kind_j: return make_record(kind, ctl_pkg::jump_i, 5'd0, 5'd0, 5'd0);
		ctl_pkg::kind_jal: return make_record(kind, ctl_pkg::jump_i, 5'd0, 5'd0, 5'd31);
		ctl_pkg::kind_jr: return make_record(kind, ctl_pkg::jump_r, rs, 5'd0, 5'd0);
		default: return make_record(kind, ctl_pkg::none, 5'd0, 5'd0, 5'd0);
	endcase
endfunction

function automatic ctl_pkg::d_ctl_t decode_controls(input ctl_pkg::stage_info_t info);
	ctl_pkg::d_ctl_t c;
	c.rf_read_addr1 = info.reg1;
	c.rf_read_addr2 = info.reg2;
	case (info.kind)
		ctl_pkg::kind_beq: c.npc_mode = ctl_pkg::npc_equal;
		ctl_pkg::kind_bne: c.npc_mode = ctl_pkg::npc_not_equal;
		ctl_pkg::kind_j, ctl_pkg::kind_jal: c.npc_mode = ctl_pkg::npc_j;
		ctl_pkg::kind_jr: c.npc_mode = ctl_pkg::npc_reg;
		default: c.npc_mode = ctl_pkg::npc_seq;
	endcase
	if (info.kind == ctl_pkg::kind_ori)
		c.ext_mode = ctl_pkg::ext_unsigned;
	else if (info.kind == ctl_pkg::kind_lui)
		c.ext_mode = ctl_pkg::ext_pad;
	else
		c.ext_mode = ctl_pkg::ext_signed;
	return c;
endfunction

function automatic ctl_pkg::e_ctl_t execute_controls(input ctl_pkg::stage_info_t info);
	ctl_pkg::e_ctl_t c;
	c.alu_src_imm = info.dp_class inside {ctl_pkg::cal_i, ctl_pkg::load, ctl_pkg::store};
	case (info.kind)
		ctl_pkg::kind_addu, ctl_pkg::kind_addiu: c.alu_op = ctl_pkg::alu_addu;
		ctl_pkg::kind_lw, ctl_pkg::kind_sw: c.alu_op = ctl_pkg::alu_addu; // address sum.
		ctl_pkg::kind_subu: c.alu_op = ctl_pkg::alu_subu;
		ctl_pkg::kind_and: c.alu_op = ctl_pkg::alu_and;
		ctl_pkg::kind_slt: c.alu_op = ctl_pkg::alu_slt;
		ctl_pkg::kind_sll: c.alu_op = ctl_pkg::alu_sll;
		ctl_pkg::kind_lui: c.alu_op = ctl_pkg::alu_lui;
		ctl_pkg::kind_or, ctl_pkg::kind_ori: c.alu_op = ctl_pkg::alu_or;
		default: c.alu_op = ctl_pkg::alu_or; // kinds without an ALU result show the or code.
	endcase
	return c;
endfunction

function automatic ctl_pkg::m_ctl_t memory_controls(input ctl_pkg::stage_info_t info);
	ctl_pkg::m_ctl_t c;
	c.dm_write_enable = (info.dp_class == ctl_pkg::store);
	return c;
endfunction

function automatic ctl_pkg::w_ctl_t writeback_controls(input ctl_pkg::stage_info_t info);
	ctl_pkg::w_ctl_t c;
	c.rf_write_addr = info.regw;
	c.rf_write_enable = (info.regw != 5'd0) &&
		!(info.dp_class inside {ctl_pkg::none, ctl_pkg::store, ctl_pkg::branch});
	case (info.dp_class)
		ctl_pkg::cal_r, ctl_pkg::cal_i: c.regdata = ctl_pkg::reg_from_alu;
		ctl_pkg::load: c.regdata = ctl_pkg::reg_from_mem;
		ctl_pkg::jump_i, ctl_pkg::jump_r: c.regdata = ctl_pkg::reg_from_link;
		default: c.regdata = ctl_pkg::reg_none;
	endcase
	return c;
endfunction

// memory counts as a source only when use_m is set and its result is already computed.
function automatic ctl_pkg::fwd_sel_t pick_source(
	input ctl_pkg::reg_addr_t src,
	input ctl_pkg::stage_info_t m, w,
	input logic use_m
);
	logic m_ready;
	m_ready = m.dp_class inside {ctl_pkg::cal_r, ctl_pkg::cal_i, ctl_pkg::jump_i};
	if (src == 5'd0)
		return ctl_pkg::fwd_none;
	if (use_m && m_ready && src == m.regw)
		return ctl_pkg::fwd_from_m;
	if (src == w.regw)
		return ctl_pkg::fwd_from_w;
	return ctl_pkg::fwd_none;
endfunction

function automatic ctl_pkg::fwd_t forward_selects(input ctl_pkg::stage_info_t d, e, m, w);
	ctl_pkg::fwd_t f;
	f.d1 = pick_source(d.reg1, m, w, 1'b1);
	f.d2 = pick_source(d.reg2, m, w, 1'b1);
	f.e1 = pick_source(e.reg1, m, w, 1'b1);
	f.e2 = pick_source(e.reg2, m, w, 1'b1);
	f.m = pick_source(m.reg2, m, w, 1'b0);
	return f;
endfunction

function automatic logic needs_stall(input ctl_pkg::stage_info_t d, e, m);
	logic early;
	logic reads_e;
	logic reads_m;
	early = d.dp_class inside {ctl_pkg::branch, ctl_pkg::jump_r};
	reads_e = (e.regw != 5'd0) && (d.reg1 == e.regw || d.reg2 == e.regw);
	reads_m = (m.regw != 5'd0) && (d.reg1 == m.regw || d.reg2 == m.regw);
	if (e.dp_class == ctl_pkg::load && reads_e)
		return 1'b1;
	if (early && reads_e && e.dp_class inside {ctl_pkg::cal_r, ctl_pkg::cal_i, ctl_pkg::jump_i})
		return 1'b1;
	return early && reads_m && m.dp_class == ctl_pkg::load;
endfunction

/* bench/tb_pipeline_ctl.sv */
`timescale 1ns/1ps

module tb_pipeline_ctl;

	localparam int directed_len = 80; // issue slots of the directed sequences.
	localparam int random_len = 200;
	localparam int cycle_limit = 4 * (directed_len + random_len);

	logic clk;
	logic rst;
	ctl_pkg::instr_t d_instr;
	logic stall;
	ctl_pkg::d_ctl_t d_ctl;
	ctl_pkg::e_ctl_t e_ctl;
	ctl_pkg::m_ctl_t m_ctl;
	ctl_pkg::w_ctl_t w_ctl;
	ctl_pkg::fwd_t fwd;
	ctl_pkg::stage_info_t model_d;
	ctl_pkg::stage_info_t model_e;
	ctl_pkg::stage_info_t model_m;
	ctl_pkg::stage_info_t model_w;
	int cycles = 0;
	int stall_count = 0;
	integer seed;

	`include "tb_encode.svh"

	pipeline_ctl pipeline_ctl_i (
		.clk(clk),
		.rst(rst),
		.d_instr(d_instr),
		.stall(stall),
		.d_ctl(d_ctl),
		.e_ctl(e_ctl),
		.m_ctl(m_ctl),
		.w_ctl(w_ctl),
		.fwd(fwd)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic report_value(input string name, input logic [31:0] got, want);
		stop_run($sformatf("FAILED %s: got %h expected %h", name, got, want));
	endtask

	// the reference pipeline holds decode while the expected stall is high.
	always @(posedge clk) begin
		if (rst) begin
			model_e <= bubble();
			model_m <= bubble();
			model_w <= bubble();
		end else begin
			model_e <= needs_stall(model_d, model_e, model_m) ? bubble() : model_d;
			model_m <= model_e;
			model_w <= model_m;
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit)
			stop_run("timeout: the stimulus did not finish within the cycle limit");
	end

	// outputs have settled by the falling edge, well before the next rising edge.
	always @(negedge clk) begin
		if (!rst) begin
			assert (stall === needs_stall(model_d, model_e, model_m))
				else report_value("stall", stall, needs_stall(model_d, model_e, model_m));
			assert (d_ctl === decode_controls(model_d))
				else report_value("d_ctl", d_ctl, decode_controls(model_d));
			assert (e_ctl === execute_controls(model_e))
				else report_value("e_ctl", e_ctl, execute_controls(model_e));
			assert (m_ctl === memory_controls(model_m))
				else report_value("m_ctl", m_ctl, memory_controls(model_m));
			assert (w_ctl === writeback_controls(model_w))
				else report_value("w_ctl", w_ctl, writeback_controls(model_w));
			assert (fwd === forward_selects(model_d, model_e, model_m, model_w))
				else report_value("fwd", fwd,
					forward_selects(model_d, model_e, model_m, model_w));
		end
	end

	// keeps the word in decode until an edge passes with stall low.
	task automatic issue_word(input ctl_pkg::instr_t word, input ctl_pkg::stage_info_t info);
		logic held;
		d_instr = word;
		model_d = info;
		held = 1'b1;
		while (held) begin
			@(negedge clk);
			held = stall;
			if (held)
				stall_count = stall_count + 1;
			@(posedge clk);
			#1;
		end
	endtask

	task automatic issue(input ctl_pkg::kind_t kind, input ctl_pkg::reg_addr_t rs, rt, rd);
		issue_word(encode(kind, rs, rt, rd), record_of(kind, rs, rt, rd));
	endtask

	task automatic drain(input int n);
		repeat (n) issue(ctl_pkg::kind_nop, 5'd0, 5'd0, 5'd0);
	endtask

	task automatic settle();
		d_instr = '0;
		model_d = bubble();
		@(negedge clk);
	endtask

	task automatic next_edge();
		@(posedge clk);
		#1;
	endtask

	task automatic check_stalls(input int n);
		drain(3);
		assert (stall_count == n) else report_value("stall cycles", stall_count, n);
		stall_count = 0;
	endtask

	initial begin
		int k;
		int i;
		logic [31:0] r;
		seed = 32'hf611;
		rst = 1'b1;
		d_instr = '0;
		model_d = bubble();
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		assert (w_ctl.rf_write_enable === 1'b0 && m_ctl.dm_write_enable === 1'b0 &&
			stall === 1'b0 && fwd === '0)
			else stop_run("outputs are not idle after reset");
		next_edge();

		// every kind once; rs is never written and each rt is unique.
		for (k = 0; k < 16; k++)
			issue(ctl_pkg::kind_t'(k), 5'd1, 5'(10 + k), 5'd2);
		check_stalls(0);

		issue(ctl_pkg::kind_lw, 5'd1, 5'd5, 5'd0);
		issue(ctl_pkg::kind_addu, 5'd5, 5'd1, 5'd6);
		check_stalls(1);
		issue(ctl_pkg::kind_addu, 5'd1, 5'd1, 5'd7);
		issue(ctl_pkg::kind_beq, 5'd7, 5'd1, 5'd0);
		check_stalls(1);
		issue(ctl_pkg::kind_lw, 5'd1, 5'd8, 5'd0);
		issue(ctl_pkg::kind_beq, 5'd8, 5'd0, 5'd0);
		check_stalls(2);

		issue(ctl_pkg::kind_addu, 5'd1, 5'd1, 5'd9);
		issue(ctl_pkg::kind_addu, 5'd9, 5'd1, 5'd10);
		settle();
		assert (fwd.e1 === ctl_pkg::fwd_from_m)
			else report_value("fwd.e1", fwd.e1, ctl_pkg::fwd_from_m);
		next_edge();
		issue(ctl_pkg::kind_addu, 5'd1, 5'd1, 5'd11);
		issue(ctl_pkg::kind_ori, 5'd1, 5'd12, 5'd0);
		issue(ctl_pkg::kind_addu, 5'd1, 5'd11, 5'd13);
		settle();
		assert (fwd.e2 === ctl_pkg::fwd_from_w)
			else report_value("fwd.e2", fwd.e2, ctl_pkg::fwd_from_w);
		next_edge();
		issue(ctl_pkg::kind_addu, 5'd1, 5'd1, 5'd15);
		issue(ctl_pkg::kind_sw, 5'd1, 5'd15, 5'd0);
		settle();
		assert (fwd.e2 === ctl_pkg::fwd_from_m)
			else report_value("fwd.e2", fwd.e2, ctl_pkg::fwd_from_m);
		next_edge();
		settle();
		assert (fwd.m === ctl_pkg::fwd_from_w)
			else report_value("fwd.m", fwd.m, ctl_pkg::fwd_from_w);
		next_edge();
		issue(ctl_pkg::kind_lw, 5'd1, 5'd14, 5'd0);
		issue(ctl_pkg::kind_sw, 5'd1, 5'd14, 5'd0);
		settle();
		assert (fwd.e2 === ctl_pkg::fwd_from_w)
			else report_value("fwd.e2", fwd.e2, ctl_pkg::fwd_from_w);
		next_edge();
		check_stalls(1);

		// register 0 as a destination, then words outside the subset.
		issue(ctl_pkg::kind_addu, 5'd1, 5'd1, 5'd0);
		issue(ctl_pkg::kind_ori, 5'd1, 5'd0, 5'd0);
		issue(ctl_pkg::kind_lw, 5'd1, 5'd0, 5'd0);
		issue(ctl_pkg::kind_addu, 5'd0, 5'd0, 5'd16);
		settle();
		assert (fwd === '0 && w_ctl.rf_write_enable === 1'b0)
			else stop_run("a write to register 0 reached the register file or forwarding");
		next_edge();
		issue_word(32'hfc00_0000, record_of(ctl_pkg::kind_unknown, 5'd0, 5'd0, 5'd0));
		issue_word(32'h0000_0001, record_of(ctl_pkg::kind_unknown, 5'd0, 5'd0, 5'd0));
		issue_word(32'h3c21_1234, record_of(ctl_pkg::kind_unknown, 5'd0, 5'd0, 5'd0));
		issue_word(32'h0022_1061, record_of(ctl_pkg::kind_unknown, 5'd0, 5'd0, 5'd0));
		settle();
		assert (fwd === '0 && w_ctl.rf_write_enable === 1'b0)
			else stop_run("an unknown word wrote a register or selected a forwarding path");
		next_edge();
		check_stalls(0);

		for (i = 0; i < random_len; i++) begin
			k = $unsigned($random(seed)) % 16;
			r = $random(seed);
			issue(ctl_pkg::kind_t'(k), r[4:0], r[9:5], r[14:10]);
		end
		drain(3);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* logic/ctl_pkg.sv */
package ctl_pkg;

	typedef logic [31:0] instr_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;

	localparam reg_addr_t reg_zero = 5'd0;
	localparam reg_addr_t reg_ra = 5'd31; // jal links here.

	localparam opcode_t op_special = 6'b000000;
	localparam opcode_t op_j = 6'b000010;
	localparam opcode_t op_jal = 6'b000011;
	localparam opcode_t op_beq = 6'b000100;
	localparam opcode_t op_bne = 6'b000101;
	localparam opcode_t op_addiu = 6'b001001;
	localparam opcode_t op_ori = 6'b001101;
	localparam opcode_t op_lui = 6'b001111;
	localparam opcode_t op_lw = 6'b100011;
	localparam opcode_t op_sw = 6'b101011;

	localparam funct_t funct_sll = 6'b000000;
	localparam funct_t funct_jr = 6'b001000;
	localparam funct_t funct_addu = 6'b100001;
	localparam funct_t funct_subu = 6'b100011;
	localparam funct_t funct_and = 6'b100100;
	localparam funct_t funct_or = 6'b100101;
	localparam funct_t funct_slt = 6'b101010;

	// the R-type field layout, which also covers the op, rs and rt of I-type words.
	typedef struct packed {
		opcode_t op;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		logic [4:0] shamt;
		funct_t funct;
	} r_fmt_t;

	typedef enum logic [4:0] {
		kind_addu, kind_subu, kind_and, kind_or, kind_slt, kind_sll,
		kind_ori, kind_addiu, kind_lui, kind_lw, kind_sw,
		kind_beq, kind_bne, kind_j, kind_jal, kind_jr,
		kind_nop, kind_unknown
	} kind_t;

	typedef enum logic [2:0] {
		cal_r, cal_i, load, store, branch, jump_i, jump_r, none
	} dp_class_t;

	typedef enum logic [2:0] {
		alu_addu, alu_subu, alu_and, alu_or, alu_slt, alu_sll, alu_lui
	} alu_op_t;

	typedef enum logic [1:0] {ext_signed, ext_unsigned, ext_pad} ext_mode_t;

	typedef enum logic [2:0] {
		npc_seq, npc_equal, npc_not_equal, npc_j, npc_reg
	} npc_mode_t;

	typedef enum logic [1:0] {
		reg_from_alu, reg_from_mem, reg_from_link, reg_none
	} regdata_t;

	typedef enum logic [1:0] {fwd_none, fwd_from_m, fwd_from_w} fwd_sel_t;

	typedef struct packed {
		kind_t kind;
		dp_class_t dp_class;
		reg_addr_t reg1;
		reg_addr_t reg2;
		reg_addr_t regw;
	} stage_info_t;

	// bubble record, with no register read or written.
	localparam stage_info_t nop_info = '{
		kind: kind_nop, dp_class: none, reg1: reg_zero, reg2: reg_zero, regw: reg_zero
	};

	typedef struct packed {
		npc_mode_t npc_mode;
		ext_mode_t ext_mode;
		reg_addr_t rf_read_addr1;
		reg_addr_t rf_read_addr2;
	} d_ctl_t;

	typedef struct packed {
		alu_op_t alu_op;
		logic alu_src_imm;
	} e_ctl_t;

	typedef struct packed {
		logic dm_write_enable;
	} m_ctl_t;

	typedef struct packed {
		logic rf_write_enable;
		reg_addr_t rf_write_addr;
		regdata_t regdata;
	} w_ctl_t;

	typedef struct packed {
		fwd_sel_t d1;
		fwd_sel_t d2;
		fwd_sel_t e1;
		fwd_sel_t e2;
		fwd_sel_t m;
	} fwd_t;

endpackage

/* logic/ctl_words.sv */
`timescale 1ns/1ps

module ctl_words (
	input ctl_pkg::stage_info_t d_info,
	input ctl_pkg::stage_info_t e_info,
	input ctl_pkg::stage_info_t m_info,
	input ctl_pkg::stage_info_t w_info,
	output ctl_pkg::d_ctl_t d_ctl,
	output ctl_pkg::e_ctl_t e_ctl,
	output ctl_pkg::m_ctl_t m_ctl,
	output ctl_pkg::w_ctl_t w_ctl
);

	logic w_writes;

	always_comb begin
		case (d_info.kind)
			ctl_pkg::kind_beq: d_ctl.npc_mode = ctl_pkg::npc_equal;
			ctl_pkg::kind_bne: d_ctl.npc_mode = ctl_pkg::npc_not_equal;
			ctl_pkg::kind_j, ctl_pkg::kind_jal: d_ctl.npc_mode = ctl_pkg::npc_j;
			ctl_pkg::kind_jr: d_ctl.npc_mode = ctl_pkg::npc_reg;
			default: d_ctl.npc_mode = ctl_pkg::npc_seq;
		endcase
		case (d_info.kind)
			ctl_pkg::kind_ori: d_ctl.ext_mode = ctl_pkg::ext_unsigned;
			ctl_pkg::kind_lui: d_ctl.ext_mode = ctl_pkg::ext_pad;
			default: d_ctl.ext_mode = ctl_pkg::ext_signed; // addiu and memory offsets.
		endcase
		d_ctl.rf_read_addr1 = d_info.reg1;
		d_ctl.rf_read_addr2 = d_info.reg2;
	end

	always_comb begin
		e_ctl.alu_src_imm = (e_info.dp_class == ctl_pkg::cal_i) ||
			(e_info.dp_class == ctl_pkg::load) ||
			(e_info.dp_class == ctl_pkg::store);
		case (e_info.kind)
			ctl_pkg::kind_addu, ctl_pkg::kind_addiu,
			ctl_pkg::kind_lw, ctl_pkg::kind_sw: e_ctl.alu_op = ctl_pkg::alu_addu;
			ctl_pkg::kind_subu: e_ctl.alu_op = ctl_pkg::alu_subu;
			ctl_pkg::kind_and: e_ctl.alu_op = ctl_pkg::alu_and;
			ctl_pkg::kind_slt: e_ctl.alu_op = ctl_pkg::alu_slt;
			ctl_pkg::kind_sll: e_ctl.alu_op = ctl_pkg::alu_sll;
			ctl_pkg::kind_lui: e_ctl.alu_op = ctl_pkg::alu_lui;
			default: e_ctl.alu_op = ctl_pkg::alu_or; // or, ori and kinds without an ALU result.
		endcase
	end

	assign m_ctl.dm_write_enable = (m_info.dp_class == ctl_pkg::store);

	// jal is the only jump that writes, and it writes the link register.
	assign w_writes = (w_info.dp_class == ctl_pkg::cal_r) ||
		(w_info.dp_class == ctl_pkg::cal_i) ||
		(w_info.dp_class == ctl_pkg::load) ||
		(w_info.dp_class == ctl_pkg::jump_i);

	always_comb begin
		w_ctl.rf_write_enable = w_writes && (w_info.regw != ctl_pkg::reg_zero);
		w_ctl.rf_write_addr = w_info.regw;
		case (w_info.dp_class)
			ctl_pkg::cal_r, ctl_pkg::cal_i: w_ctl.regdata = ctl_pkg::reg_from_alu;
			ctl_pkg::load: w_ctl.regdata = ctl_pkg::reg_from_mem;
			ctl_pkg::jump_i, ctl_pkg::jump_r: w_ctl.regdata = ctl_pkg::reg_from_link;
			default: w_ctl.regdata = ctl_pkg::reg_none;
		endcase
	end

endmodule

/* logic/forward_unit.sv */
`timescale 1ns/1ps

module forward_unit (
	input ctl_pkg::stage_info_t d_info,
	input ctl_pkg::stage_info_t e_info,
	input ctl_pkg::stage_info_t m_info,
	input ctl_pkg::stage_info_t w_info,
	output ctl_pkg::fwd_t fwd
);

	logic m_ready;
	ctl_pkg::reg_addr_t m_src_reg;

	// picks the nearest stage that holds a finished value for src.
	function automatic ctl_pkg::fwd_sel_t pick(
		input ctl_pkg::reg_addr_t src,
		input ctl_pkg::reg_addr_t m_reg,
		input ctl_pkg::reg_addr_t w_reg
	);
		ctl_pkg::fwd_sel_t sel;
		sel = ctl_pkg::fwd_none;
		if (src != ctl_pkg::reg_zero) begin
			if (src == m_reg) sel = ctl_pkg::fwd_from_m;
			else if (src == w_reg) sel = ctl_pkg::fwd_from_w;
		end
		return sel;
	endfunction

	// a load in memory has no data yet, so it is never a forwarding source.
	assign m_ready = (m_info.dp_class == ctl_pkg::cal_r) ||
		(m_info.dp_class == ctl_pkg::cal_i) ||
		(m_info.dp_class == ctl_pkg::jump_i);
	assign m_src_reg = m_ready ? m_info.regw : ctl_pkg::reg_zero;

	always_comb begin
		fwd.d1 = pick(d_info.reg1, m_src_reg, w_info.regw);
		fwd.d2 = pick(d_info.reg2, m_src_reg, w_info.regw);
		fwd.e1 = pick(e_info.reg1, m_src_reg, w_info.regw);
		fwd.e2 = pick(e_info.reg2, m_src_reg, w_info.regw);
		fwd.m = pick(m_info.reg2, ctl_pkg::reg_zero, w_info.regw); // store data only.
	end

endmodule

/* logic/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
	input ctl_pkg::stage_info_t d_info,
	input ctl_pkg::stage_info_t e_info,
	input ctl_pkg::stage_info_t m_info,
	output logic stall
);

	logic d_early;
	logic e_load;
	logic e_alu;
	logic m_load;
	logic hit_e;
	logic hit_m;

	// true when decode reads regw, register 0 excluded.
	function automatic logic reads(
		input ctl_pkg::stage_info_t d,
		input ctl_pkg::reg_addr_t regw
	);
		return (regw != ctl_pkg::reg_zero) && ((d.reg1 == regw) || (d.reg2 == regw));
	endfunction

	// branches and jr compare their operands in decode, one stage earlier than the ALU.
	assign d_early = (d_info.dp_class == ctl_pkg::branch) ||
		(d_info.dp_class == ctl_pkg::jump_r);

	assign e_load = (e_info.dp_class == ctl_pkg::load);
	assign e_alu = (e_info.dp_class == ctl_pkg::cal_r) ||
		(e_info.dp_class == ctl_pkg::cal_i) ||
		(e_info.dp_class == ctl_pkg::jump_i);
	assign m_load = (m_info.dp_class == ctl_pkg::load);

	assign hit_e = reads(d_info, e_info.regw);
	assign hit_m = reads(d_info, m_info.regw);

	assign stall = (e_load && hit_e) ||
		(e_alu && d_early && hit_e) ||
		(m_load && d_early && hit_m);

endmodule

/* logic/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
	input ctl_pkg::instr_t instr,
	output ctl_pkg::stage_info_t info
);

	ctl_pkg::r_fmt_t f;
	ctl_pkg::kind_t kind;
	ctl_pkg::dp_class_t dp_class;
	logic rs_zero;
	logic rt_zero;
	logic rd_zero;
	logic shamt_zero;

	assign f = instr;

	assign rs_zero = (f.rs == ctl_pkg::reg_zero);
	assign rt_zero = (f.rt == ctl_pkg::reg_zero);
	assign rd_zero = (f.rd == ctl_pkg::reg_zero);
	assign shamt_zero = (f.shamt == 5'd0);

	// fields that an instruction does not use must be zero, or the word is unknown.
	always_comb begin
		kind = ctl_pkg::kind_unknown;
		if (instr == '0) begin
			kind = ctl_pkg::kind_nop; // the all-zero word would otherwise be sll $0.
		end else begin
			case (f.op)
				ctl_pkg::op_special: begin
					case (f.funct)
						ctl_pkg::funct_addu: if (shamt_zero) kind = ctl_pkg::kind_addu;
						ctl_pkg::funct_subu: if (shamt_zero) kind = ctl_pkg::kind_subu;
						ctl_pkg::funct_and: if (shamt_zero) kind = ctl_pkg::kind_and;
						ctl_pkg::funct_or: if (shamt_zero) kind = ctl_pkg::kind_or;
						ctl_pkg::funct_slt: if (shamt_zero) kind = ctl_pkg::kind_slt;
						ctl_pkg::funct_sll: if (rs_zero) kind = ctl_pkg::kind_sll;
						ctl_pkg::funct_jr: if (rt_zero && rd_zero) kind = ctl_pkg::kind_jr;
						default: kind = ctl_pkg::kind_unknown;
					endcase
				end
				ctl_pkg::op_ori: kind = ctl_pkg::kind_ori;
				ctl_pkg::op_addiu: kind = ctl_pkg::kind_addiu;
				ctl_pkg::op_lui: if (rs_zero) kind = ctl_pkg::kind_lui;
				ctl_pkg::op_lw: kind = ctl_pkg::kind_lw;
				ctl_pkg::op_sw: kind = ctl_pkg::kind_sw;
				ctl_pkg::op_beq: kind = ctl_pkg::kind_beq;
				ctl_pkg::op_bne: kind = ctl_pkg::kind_bne;
				ctl_pkg::op_j: kind = ctl_pkg::kind_j;
				ctl_pkg::op_jal: kind = ctl_pkg::kind_jal;
				default: kind = ctl_pkg::kind_unknown;
			endcase
		end
	end

	always_comb begin
		case (kind)
			ctl_pkg::kind_addu, ctl_pkg::kind_subu, ctl_pkg::kind_and,
			ctl_pkg::kind_or, ctl_pkg::kind_slt, ctl_pkg::kind_sll: dp_class = ctl_pkg::cal_r;
			ctl_pkg::kind_ori, ctl_pkg::kind_addiu, ctl_pkg::kind_lui: dp_class = ctl_pkg::cal_i;
			ctl_pkg::kind_lw: dp_class = ctl_pkg::load;
			ctl_pkg::kind_sw: dp_class = ctl_pkg::store;
			ctl_pkg::kind_beq, ctl_pkg::kind_bne: dp_class = ctl_pkg::branch;
			ctl_pkg::kind_j, ctl_pkg::kind_jal: dp_class = ctl_pkg::jump_i;
			ctl_pkg::kind_jr: dp_class = ctl_pkg::jump_r;
			default: dp_class = ctl_pkg::none; // nop and unknown words do nothing.
		endcase
	end

	always_comb begin
		info.kind = kind;
		info.dp_class = dp_class;
		info.reg1 = ctl_pkg::reg_zero;
		info.reg2 = ctl_pkg::reg_zero;
		info.regw = ctl_pkg::reg_zero;
		case (dp_class)
			ctl_pkg::cal_r, ctl_pkg::store, ctl_pkg::branch: begin
				info.reg1 = f.rs;
				info.reg2 = f.rt;
				if (dp_class == ctl_pkg::cal_r) info.regw = f.rd;
			end
			ctl_pkg::cal_i, ctl_pkg::load: begin
				info.reg1 = f.rs;
				info.regw = f.rt;
			end
			ctl_pkg::jump_r: info.reg1 = f.rs;
			ctl_pkg::jump_i: if (kind == ctl_pkg::kind_jal) info.regw = ctl_pkg::reg_ra;
			default: info.regw = ctl_pkg::reg_zero;
		endcase
	end

endmodule

/* logic/pipeline_ctl.sv */
`timescale 1ns/1ps

module pipeline_ctl (
	input logic clk,
	input logic rst,
	input ctl_pkg::instr_t d_instr,
	output logic stall,
	output ctl_pkg::d_ctl_t d_ctl,
	output ctl_pkg::e_ctl_t e_ctl,
	output ctl_pkg::m_ctl_t m_ctl,
	output ctl_pkg::w_ctl_t w_ctl,
	output ctl_pkg::fwd_t fwd
);

	ctl_pkg::stage_info_t d_info;
	ctl_pkg::stage_info_t e_info;
	ctl_pkg::stage_info_t m_info;
	ctl_pkg::stage_info_t w_info;

	instr_decoder decoder_i (
		.instr(d_instr),
		.info(d_info)
	);

	// the decoded record is all that travels past decode.
	stage_regs stage_regs_i (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.d_info(d_info),
		.e_info(e_info),
		.m_info(m_info),
		.w_info(w_info)
	);

	ctl_words ctl_words_i (
		.d_info(d_info),
		.e_info(e_info),
		.m_info(m_info),
		.w_info(w_info),
		.d_ctl(d_ctl),
		.e_ctl(e_ctl),
		.m_ctl(m_ctl),
		.w_ctl(w_ctl)
	);

	forward_unit forward_i (
		.d_info(d_info),
		.e_info(e_info),
		.m_info(m_info),
		.w_info(w_info),
		.fwd(fwd)
	);

	hazard_unit hazard_i (
		.d_info(d_info),
		.e_info(e_info),
		.m_info(m_info),
		.stall(stall)
	);

endmodule

/* logic/stage_regs.sv */
`timescale 1ns/1ps

module stage_regs (
	input logic clk,
	input logic rst,
	input logic stall,
	input ctl_pkg::stage_info_t d_info,
	output ctl_pkg::stage_info_t e_info,
	output ctl_pkg::stage_info_t m_info,
	output ctl_pkg::stage_info_t w_info
);

	// a stall leaves decode in place, so execute takes a bubble instead.
	always_ff @(posedge clk) begin
		if (rst || stall) begin
			e_info <= ctl_pkg::nop_info;
		end else begin
			e_info <= d_info;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			m_info <= ctl_pkg::nop_info;
			w_info <= ctl_pkg::nop_info;
		end else begin
			m_info <= e_info; // memory and writeback never hold.
			w_info <= m_info;
		end
	end

endmodule

/* pipeline_ctl.f */
+incdir+bench
logic/ctl_pkg.sv
logic/instr_decoder.sv
logic/stage_regs.sv
logic/ctl_words.sv
logic/forward_unit.sv
logic/hazard_unit.sv
logic/pipeline_ctl.sv
bench/tb_pipeline_ctl.sv
